// File: hdl/axil_sram_pkg.sv
`default_nettype none

package axil_sram_pkg;

  // ==========================================================================
  // bus widths
  // ==========================================================================

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;  // one strobe per byte lane

  // ==========================================================================
  // encodings
  // ==========================================================================

  // axi response codes, only the two this slave can return
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_t;

  // request kind on the internal request/response paths
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } op_t;

  // latency core FSM
  typedef enum logic [1:0] {
    st_idle,  // waiting for a request
    st_wait,  // counting down the random delay
    st_resp   // response offered to the output side
  } core_state_t;

endpackage

`default_nettype wire

// File: hdl/mem_req_if.sv
`default_nettype none

// one memory request, front to core
interface mem_req_if;
  import axil_sram_pkg::*;

  logic              valid;
  logic              ready;
  op_t               op;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;  // don't-care for reads
  logic [strb_w-1:0] wstrb;  // don't-care for reads

  modport src (
    output valid,
    output op,
    output addr,
    output wdata,
    output wstrb,
    input  ready
  );

  modport dst (
    input  valid,
    input  op,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready
  );

endinterface

`default_nettype wire

// File: hdl/mem_rsp_if.sv
`default_nettype none

// one finished access, core to output side
interface mem_rsp_if;
  import axil_sram_pkg::*;

  logic              valid;
  logic              ready;
  op_t               op;     // selects R or B
  logic [data_w-1:0] rdata;
  resp_t             resp;

  modport src (
    output valid,
    output op,
    output rdata,
    output resp,
    input  ready
  );

  modport dst (
    input  valid,
    input  op,
    input  rdata,
    input  resp,
    output ready
  );

endinterface

`default_nettype wire

// File: hdl/lfsr8.sv
`default_nettype none

module lfsr8 #(
  parameter logic [7:0] seed = 8'h01
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic       step,
  output logic [7:0] value
);

  logic [7:0] state;
  logic       fb;

  // taps 8,6,5,4
  assign fb    = state[7] ^ state[5] ^ state[4] ^ state[3];
  assign value = state;

  always_ff @(posedge clk) begin
    if (rstn)
      state <= seed;
    else if (step)
      state <= {state[6:0], fb};
  end

  a_nonzero: assert property (@(posedge clk) disable iff (rstn) state != 8'd0);

endmodule

`default_nettype wire

// File: hdl/axil_front.sv
`default_nettype none

module axil_front (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [axil_sram_pkg::addr_w-1:0]  araddr,
  input  logic                              arvalid,
  output logic                              arready,
  input  logic [axil_sram_pkg::addr_w-1:0]  awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [axil_sram_pkg::data_w-1:0]  wdata,
  input  logic [axil_sram_pkg::strb_w-1:0]  wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  mem_req_if.src                            req
);
  import axil_sram_pkg::*;

  logic              rd_full;
  logic [addr_w-1:0] rd_addr;
  logic              aw_full;
  logic [addr_w-1:0] wr_addr;
  logic              w_full;
  logic [data_w-1:0] wr_data;
  logic [strb_w-1:0] wr_strb;
  logic              wr_full;
  logic              turn_wr;  // write wins the next tie
  logic              locked;   // offer pending, choice frozen
  op_t               lock_op;
  op_t               sel_op;
  logic              req_fire;

  assign arready = !rd_full;
  assign awready = !aw_full;
  assign wready  = !w_full;
  assign wr_full = aw_full && w_full;

  // ==========================================================================
  // read/write arbitration
  // ==========================================================================

  always_comb begin
    if (locked) begin
      sel_op = lock_op;
    end else if (rd_full && wr_full) begin
      sel_op = turn_wr ? op_write : op_read;
    end else if (wr_full) begin
      sel_op = op_write;
    end else begin
      sel_op = op_read;
    end
  end

  assign req.valid = rd_full || wr_full;
  assign req.op    = sel_op;
  assign req.addr  = (sel_op == op_write) ? wr_addr : rd_addr;
  assign req.wdata = wr_data;
  assign req.wstrb = wr_strb;
  assign req_fire  = req.valid && req.ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_full <= 1'b0;
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      turn_wr <= 1'b0;
      locked  <= 1'b0;
      lock_op <= op_read;
    end else begin
      if (arvalid && arready)
        rd_full <= 1'b1;
      else if (req_fire && sel_op == op_read)
        rd_full <= 1'b0;

      // the two write halves fill independently
      if (awvalid && awready)
        aw_full <= 1'b1;
      else if (req_fire && sel_op == op_write)
        aw_full <= 1'b0;

      if (wvalid && wready)
        w_full <= 1'b1;
      else if (req_fire && sel_op == op_write)
        w_full <= 1'b0;

      if (req_fire)
        turn_wr <= (sel_op == op_read);

      // hold op stable while the core stalls
      if (req_fire) begin
        locked <= 1'b0;
      end else if (req.valid) begin
        locked  <= 1'b1;
        lock_op <= sel_op;
      end
    end
  end

  // slot payload
  always_ff @(posedge clk) begin
    if (arvalid && arready)
      rd_addr <= araddr;
    if (awvalid && awready)
      wr_addr <= awaddr;
    if (wvalid && wready) begin
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
  end

  // a write leaves only as a pair, and frees both halves
  a_write_pair: assert property (@(posedge clk) disable iff (rstn)
    req_fire && req.op == op_write |-> aw_full && w_full ##1 !aw_full && !w_full);

endmodule

`default_nettype wire

// File: hdl/latency_core.sv
`default_nettype none

module latency_core #(
  parameter int         depth     = 256,
  parameter int         min_lat   = 1,
  parameter logic [7:0] lfsr_seed = 8'hA5
) (
  input  logic   clk,
  input  logic   rstn,
  mem_req_if.dst req,
  mem_rsp_if.src rsp
);
  import axil_sram_pkg::*;

  localparam int cnt_w = $clog2(min_lat + 8);
  localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

  logic [data_w-1:0] mem [depth];

  core_state_t       state;
  logic [cnt_w-1:0]  count;
  op_t               op_q;
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [strb_w-1:0] wstrb_q;
  logic [data_w-1:0] rdata_q;
  resp_t             resp_q;
  logic [7:0]        rand_val;
  logic              accept;
  logic              expire;
  logic [addr_w-3:0] word;
  logic              in_range;
  logic [idx_w-1:0]  idx;

  assign accept   = req.valid && req.ready;
  assign expire   = (state == st_wait) && (count <= 1);
  assign word     = addr_q[addr_w-1:2];          // byte address to word index
  assign in_range = word < (addr_w-2)'(depth);
  assign idx      = word[idx_w-1:0];

  assign req.ready = (state == st_idle);
  assign rsp.valid = (state == st_resp);
  assign rsp.op    = op_q;
  assign rsp.rdata = rdata_q;
  assign rsp.resp  = resp_q;

  lfsr8 #(
    .seed(lfsr_seed)
  ) u_lfsr (
    .clk(clk),
    .rstn(rstn),
    .step(accept),
    .value(rand_val)
  );

  // ==========================================================================
  // delay FSM
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_wait;
            count <= cnt_w'(min_lat) + cnt_w'(rand_val[2:0]);  // min_lat .. min_lat+7
          end
        end
        st_wait: begin
          if (expire)
            state <= st_resp;
          else
            count <= count - 1'b1;
        end
        st_resp: begin
          if (rsp.ready)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= req.op;
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
      wstrb_q <= req.wstrb;
    end
    if (expire) begin
      resp_q <= in_range ? resp_okay : resp_slverr;
      if (op_q == op_read && in_range)
        rdata_q <= mem[idx];
      else
        rdata_q <= '0;  // slverr and writes carry zero data
    end
  end

  // byte merge, out of range writes dropped
  always_ff @(posedge clk) begin
    if (expire && op_q == op_write && in_range) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wstrb_q[b])
          mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (rstn)
    state == st_wait |-> count <= min_lat + 7);

endmodule

`default_nettype wire

// File: hdl/axil_resp.sv
`default_nettype none

module axil_resp (
  input  logic                             clk,
  input  logic                             rstn,
  mem_rsp_if.dst                           rsp,
  output logic [axil_sram_pkg::data_w-1:0] rdata,
  output axil_sram_pkg::resp_t             rresp,
  output logic                             rvalid,
  input  logic                             rready,
  output axil_sram_pkg::resp_t             bresp,
  output logic                             bvalid,
  input  logic                             bready
);
  import axil_sram_pkg::*;

  logic take;

  // ready when the target register is empty or draining now
  assign rsp.ready = (rsp.op == op_read) ? (!rvalid || rready) : (!bvalid || bready);
  assign take      = rsp.valid && rsp.ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (take && rsp.op == op_read)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;

      if (take && rsp.op == op_write)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take && rsp.op == op_read) begin
      rdata <= rsp.rdata;
      rresp <= rsp.resp;
    end
    if (take && rsp.op == op_write)
      bresp <= rsp.resp;
  end

  a_r_hold: assert property (@(posedge clk) disable iff (rstn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

  a_b_hold: assert property (@(posedge clk) disable iff (rstn)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

// File: hdl/axil_sram_top.sv
`default_nettype none

module axil_sram_top #(
  parameter int         depth     = 256,
  parameter int         min_lat   = 1,
  parameter logic [7:0] lfsr_seed = 8'hA5
) (
  input  logic                             clk,
  input  logic                             rstn,
  // read address
  input  logic [axil_sram_pkg::addr_w-1:0] araddr,
  input  logic                             arvalid,
  output logic                             arready,
  // read data
  output logic [axil_sram_pkg::data_w-1:0] rdata,
  output axil_sram_pkg::resp_t             rresp,
  output logic                             rvalid,
  input  logic                             rready,
  // write address
  input  logic [axil_sram_pkg::addr_w-1:0] awaddr,
  input  logic                             awvalid,
  output logic                             awready,
  // write data
  input  logic [axil_sram_pkg::data_w-1:0] wdata,
  input  logic [axil_sram_pkg::strb_w-1:0] wstrb,
  input  logic                             wvalid,
  output logic                             wready,
  // write response
  output axil_sram_pkg::resp_t             bresp,
  output logic                             bvalid,
  input  logic                             bready
);

  mem_req_if req_bus ();
  mem_rsp_if rsp_bus ();

  axil_front u_front (
    .clk(clk),
    .rstn(rstn),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .req(req_bus.src)
  );

  latency_core #(
    .depth(depth),
    .min_lat(min_lat),
    .lfsr_seed(lfsr_seed)
  ) u_core (
    .clk(clk),
    .rstn(rstn),
    .req(req_bus.dst),
    .rsp(rsp_bus.src)
  );

  axil_resp u_resp (
    .clk(clk),
    .rstn(rstn),
    .rsp(rsp_bus.dst),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready)
  );

endmodule

`default_nettype wire

// File: testbench/tb_axil_sram.sv
`default_nettype none

module tb_axil_sram;
  timeunit 1ns;
  timeprecision 100ps;
  import axil_sram_pkg::*;

  localparam int depth   = 64;
  localparam int min_lat = 1;

  logic              clk = 1'b0;
  logic              rstn;
  logic [addr_w-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [data_w-1:0] rdata;
  resp_t             rresp;
  logic              rvalid;
  logic              rready;
  logic [addr_w-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  resp_t             bresp;
  logic              bvalid;
  logic              bready;

  logic [data_w-1:0] ref_mem [depth];
  logic [data_w-1:0] exp_rdata [$];
  resp_t             exp_rresp [$];
  resp_t             exp_bresp [$];
  logic [addr_w-3:0] rd_words [$];  // word index per read in flight
  logic [addr_w-3:0] wr_words [$];  // word index per write in flight
  string             test_name = "reset";
  logic              rand_ready = 1'b0;
  int unsigned       cycle_cnt = 0;
  int unsigned       ar_edge;
  logic [3:0]        strbs [5] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};

  axil_sram_top #(.depth(depth), .min_lat(min_lat), .lfsr_seed(8'hA5)) UUT (
    .clk(clk), .rstn(rstn),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ==========================================================================
  // reference model and checks
  // ==========================================================================

  function automatic resp_t ref_access(input op_t op, input logic [addr_w-1:0] addr,
                                       input logic [data_w-1:0] wd,
                                       input logic [strb_w-1:0] ws,
                                       output logic [data_w-1:0] rd);
    logic [addr_w-3:0] word;
    word = addr[addr_w-1:2];
    rd = '0;
    if (word >= (addr_w-2)'(depth))
      return resp_slverr;  // nothing stored
    if (op == op_read) begin
      rd = ref_mem[int'(word)];
    end else begin
      for (int b = 0; b < strb_w; b++) begin
        if (ws[b])
          ref_mem[int'(word)][8*b +: 8] = wd[8*b +: 8];
      end
    end
    return resp_okay;
  endfunction

  // word still in flight on the write side (wr_side high) or the read side
  function automatic logic word_in_flight(input logic [addr_w-1:0] a, input logic wr_side);
    logic hit;
    hit = 1'b0;
    if (wr_side) begin
      foreach (wr_words[i])
        if (wr_words[i] == a[addr_w-1:2])
          hit = 1'b1;
    end else begin
      foreach (rd_words[i])
        if (rd_words[i] == a[addr_w-1:2])
          hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
  endtask

  // response monitor, in issue order per channel
  always @(posedge clk) begin
    if (!rstn && rvalid && rready) begin
      if (exp_rresp.size() == 0) begin
        report_failure("read response arrived with no read outstanding");
      end else begin
        check_data({test_name, " rdata"}, exp_rdata.pop_front(), rdata);
        check_resp({test_name, " rresp"}, exp_rresp.pop_front(), rresp);
        void'(rd_words.pop_front());
      end
    end
    if (!rstn && bvalid && bready) begin
      if (exp_bresp.size() == 0) begin
        report_failure("write response arrived with no write outstanding");
      end else begin
        check_resp({test_name, " bresp"}, exp_bresp.pop_front(), bresp);
        void'(wr_words.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (rand_ready) begin
      rready <= 1'($urandom_range(0, 1));
      bready <= 1'($urandom_range(0, 1));
    end else begin
      rready <= 1'b1;
      bready <= 1'b1;
    end
  end

  // ==========================================================================
  // bus tasks
  // ==========================================================================

  task automatic read_word(input logic [addr_w-1:0] a);
    logic [data_w-1:0] rd;
    resp_t             r;
    int                n;
    r = ref_access(op_read, a, '0, '0, rd);
    exp_rdata.push_back(rd);
    exp_rresp.push_back(r);
    rd_words.push_back(a[addr_w-1:2]);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= a;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 100)
        report_failure("timeout waiting for arready");
    end while (!arready);
    ar_edge = cycle_cnt;
    arvalid <= 1'b0;
  endtask

  // order 0 same cycle, 1 AW first, 2 W first
  task automatic write_word(input logic [addr_w-1:0] a, input logic [data_w-1:0] d,
                            input logic [strb_w-1:0] s, input int order);
    logic [data_w-1:0] rd;
    logic              aw_done;
    logic              w_done;
    int                n;
    exp_bresp.push_back(ref_access(op_write, a, d, s, rd));
    wr_words.push_back(a[addr_w-1:2]);
    aw_done = 1'b0;
    w_done  = 1'b0;
    n = 0;
    @(posedge clk);
    if (order != 2) begin
      awvalid <= 1'b1;
      awaddr  <= a;
    end
    if (order != 1) begin
      wvalid <= 1'b1;
      wdata  <= d;
      wstrb  <= s;
    end
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      n++;
      if (n > 100)
        report_failure("timeout waiting for awready or wready");
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end
      if (aw_done && !w_done && !wvalid) begin  // second half now
        wvalid <= 1'b1;
        wdata  <= d;
        wstrb  <= s;
      end
      if (w_done && !aw_done && !awvalid) begin
        awvalid <= 1'b1;
        awaddr  <= a;
      end
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 100)
        report_failure("timeout waiting for outstanding responses");
    end while (exp_rdata.size() != 0 || exp_bresp.size() != 0);
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial begin
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    logic [strb_w-1:0] s;
    logic              wr;
    int                ord;
    int unsigned       lat;
    void'($urandom(27));
    rstn = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    rready = 1'b1;
    bready = 1'b1;
    for (int i = 0; i < depth; i++)
      ref_mem[i] = '0;
    repeat (10) @(posedge clk);
    rstn <= 1'b0;
    @(posedge clk);
    check_flag("reset arready", 1'b1, arready);
    check_flag("reset awready", 1'b1, awready);
    check_flag("reset wready", 1'b1, wready);
    check_flag("reset rvalid", 1'b0, rvalid);
    check_flag("reset bvalid", 1'b0, bvalid);

    test_name = "fill";
    for (int i = 0; i < depth; i++) begin
      write_word(i * 4, (32'h9e3779b9 * (i + 1)) ^ i, 4'hf, i % 3);
      wait_idle();
    end

    test_name = "write order";
    for (int k = 0; k < 3; k++) begin
      write_word((k + 5) * 4, 32'hc0de_0000 + k, 4'hf, k);
      wait_idle();
      read_word((k + 5) * 4);
      wait_idle();
    end

    test_name = "partial strobe";
    foreach (strbs[k]) begin
      write_word(20 * 4, $urandom, strbs[k], k % 3);
      wait_idle();
      read_word(20 * 4);
      wait_idle();
    end

    test_name = "out of range";
    write_word(depth * 4, 32'hdead_beef, 4'hf, 0);
    wait_idle();
    write_word(32'hffff_fffc, 32'h1234_5678, 4'hf, 1);
    wait_idle();
    read_word(depth * 4 + 8);
    wait_idle();
    for (int i = 0; i < depth; i++) begin
      read_word(i * 4);
      wait_idle();
    end

    test_name = "random";
    rand_ready <= 1'b1;
    for (int i = 0; i < 300; i++) begin
      if ($urandom_range(0, 9) == 0)
        a = $urandom;
      else
        a = $urandom_range(0, 79) * 4;  // top 16 words out of range
      d = $urandom;
      s = 4'($urandom);
      ord = $urandom_range(0, 2);
      wr = ($urandom_range(0, 1) == 1);
      if (word_in_flight(a, !wr))
        wait_idle();  // read and write to one word may swap in arbitration
      if (wr)
        write_word(a, d, s, ord);
      else
        read_word(a);
    end
    wait_idle();

    test_name = "latency";
    rand_ready <= 1'b0;
    for (int i = 0; i < 20; i++) begin
      read_word($urandom_range(0, depth - 1) * 4);
      for (int n = 0; !rvalid; n++) begin
        @(posedge clk);
        if (n > 100)
          report_failure("timeout waiting for rvalid");
      end
      lat = cycle_cnt - ar_edge;
      if (lat < min_lat + 3 || lat > min_lat + 10)
        report_failure($sformatf("MISMATCH %s: expected %0d..%0d cycles, actual %0d",
                                 test_name, min_lat + 3, min_lat + 10, lat));
      wait_idle();
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hdl/axil_sram_pkg.sv
hdl/mem_req_if.sv
hdl/mem_rsp_if.sv
hdl/lfsr8.sv
hdl/axil_front.sv
hdl/latency_core.sv
hdl/axil_resp.sv
hdl/axil_sram_top.sv
testbench/tb_axil_sram.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axil_sram
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
